// ==== compile.f ====
+incdir+src
src/ttc_pkg.sv
src/ttc_timer_regs.sv
src/ttc_apb_regs.sv
tests/ttc_apb_regs_props.sv
tests/ttc_apb_regs_tb.sv

// ==== tests/ttc_apb_regs_tb.sv ====
/*
 * Random-stimulus testbench for the timer/counter APB register block.
 * A model derives selects and clear pulses from the current bus inputs, and
 * prdata from the inputs one cycle earlier. Outputs are sampled on the
 * falling edge. The run stops at the first mismatch.
 */

`include "ttc_defines.svh"

module ttc_apb_regs_tb;

  import ttc_pkg::*;

  // ------------------------------------------------------------------------
  // Signals and settings
  // ------------------------------------------------------------------------

  localparam int num_cycles    = 3000;                // Random bus cycles
  localparam int reset_timeout = 20;                  // Cycles allowed for reset

  logic      pclk28;
  logic      n_p_reset28;
  logic      psel;
  logic      penable;
  logic      pwrite;
  addr_t     paddr;
  ctrl_reg_t clk_ctrl_reg     [1:`TTC_NUM_TIMERS];
  ctrl_reg_t cntr_ctrl_reg    [1:`TTC_NUM_TIMERS];
  count_t    counter_val_reg  [1:`TTC_NUM_TIMERS];
  count_t    interval_reg     [1:`TTC_NUM_TIMERS];
  count_t    match_1_reg      [1:`TTC_NUM_TIMERS];
  count_t    match_2_reg      [1:`TTC_NUM_TIMERS];
  count_t    match_3_reg      [1:`TTC_NUM_TIMERS];
  irq_t      interrupt_reg    [1:`TTC_NUM_TIMERS];
  irq_t      interrupt_en_reg [1:`TTC_NUM_TIMERS];
  prdata_t   prdata;
  logic [`TTC_NUM_TIMERS:1] clk_ctrl_reg_sel;
  logic [`TTC_NUM_TIMERS:1] cntr_ctrl_reg_sel;
  logic [`TTC_NUM_TIMERS:1] interval_reg_sel;
  logic [`TTC_NUM_TIMERS:1] match_1_reg_sel;
  logic [`TTC_NUM_TIMERS:1] match_2_reg_sel;
  logic [`TTC_NUM_TIMERS:1] match_3_reg_sel;
  logic [`TTC_NUM_TIMERS:1] intr_en_reg_sel;
  logic [`TTC_NUM_TIMERS:1] clear_interrupt;

  integer  seed;                                      // $random state
  prdata_t exp_prdata;                                // Word captured last edge
  int      wait_cycles;                               // Reset wait counter

  ttc_apb_regs dut_i (
    .pclk28            (pclk28),
    .n_p_reset28       (n_p_reset28),
    .psel              (psel),
    .penable           (penable),
    .pwrite            (pwrite),
    .paddr             (paddr),
    .clk_ctrl_reg      (clk_ctrl_reg),
    .cntr_ctrl_reg     (cntr_ctrl_reg),
    .counter_val_reg   (counter_val_reg),
    .interval_reg      (interval_reg),
    .match_1_reg       (match_1_reg),
    .match_2_reg       (match_2_reg),
    .match_3_reg       (match_3_reg),
    .interrupt_reg     (interrupt_reg),
    .interrupt_en_reg  (interrupt_en_reg),
    .prdata            (prdata),
    .clk_ctrl_reg_sel  (clk_ctrl_reg_sel),
    .cntr_ctrl_reg_sel (cntr_ctrl_reg_sel),
    .interval_reg_sel  (interval_reg_sel),
    .match_1_reg_sel   (match_1_reg_sel),
    .match_2_reg_sel   (match_2_reg_sel),
    .match_3_reg_sel   (match_3_reg_sel),
    .intr_en_reg_sel   (intr_en_reg_sel),
    .clear_interrupt   (clear_interrupt)
  );

  always #2 pclk28 = ~pclk28;                         // Period 4

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------

  // Kind 0 to 8 in map order, timer 1 to 3
  function automatic addr_t reg_addr(input int kind, input int timer);
    int base;
    case (kind)
      0:       base = 'h00;                           // Clock control
      1:       base = 'h0C;                           // Counter control
      2:       base = 'h18;                           // Counter value
      3:       base = 'h24;                           // Interval
      4:       base = 'h30;                           // Match 1
      5:       base = 'h3C;
      6:       base = 'h48;
      7:       base = 'h54;                           // Interrupt status
      default: base = 'h60;                           // Interrupt enable
    endcase
    return addr_t'(base + 4 * (timer - 1));
  endfunction

  // Word the bus should capture at the next edge
  function automatic prdata_t model_read_word();
    prdata_t word;
    word = '0;
    if (psel && !pwrite)
    begin
      for (int t = 1; t <= `TTC_NUM_TIMERS; t++)
      begin
        if (paddr == reg_addr(0, t)) word = {25'b0, clk_ctrl_reg[t]};
        if (paddr == reg_addr(1, t)) word = {25'b0, cntr_ctrl_reg[t]};
        if (paddr == reg_addr(2, t)) word = {16'b0, counter_val_reg[t]};
        if (paddr == reg_addr(3, t)) word = {16'b0, interval_reg[t]};
        if (paddr == reg_addr(4, t)) word = {16'b0, match_1_reg[t]};
        if (paddr == reg_addr(5, t)) word = {16'b0, match_2_reg[t]};
        if (paddr == reg_addr(6, t)) word = {16'b0, match_3_reg[t]};
        if (paddr == reg_addr(7, t)) word = {26'b0, interrupt_reg[t]};
        if (paddr == reg_addr(8, t)) word = {26'b0, interrupt_en_reg[t]};
      end
    end
    return word;
  endfunction

  // ------------------------------------------------------------------------
  // Stimulus and checking
  // ------------------------------------------------------------------------

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "Simulation stopped at time %0t", $time);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      stop_with_failure($sformatf("Error: %s is %h, expected %h", name, actual, expected));
    end
  endtask

  task automatic drive_random_cycle();
    psel    <= $random(seed);                         // Bit 0 only
    penable <= $random(seed);
    pwrite  <= $random(seed);
    if (({$random(seed)} % 4) != 0)                   // Mostly mapped addresses
    begin
      paddr <= reg_addr({$random(seed)} % 9, {$random(seed)} % 3 + 1);
    end
    else
    begin
      paddr <= addr_t'($random(seed));                // Any byte, aligned or not
    end
    for (int t = 1; t <= `TTC_NUM_TIMERS; t++)
    begin
      clk_ctrl_reg[t]     <= ctrl_reg_t'($random(seed));
      cntr_ctrl_reg[t]    <= ctrl_reg_t'($random(seed));
      counter_val_reg[t]  <= count_t'($random(seed));
      interval_reg[t]     <= count_t'($random(seed));
      match_1_reg[t]      <= count_t'($random(seed));
      match_2_reg[t]      <= count_t'($random(seed));
      match_3_reg[t]      <= count_t'($random(seed));
      interrupt_reg[t]    <= irq_t'($random(seed));
      interrupt_en_reg[t] <= irq_t'($random(seed));
    end
  endtask

  task automatic check_outputs();
    logic wr;
    logic rd_acc;
    wr     = psel & penable & pwrite;                 // Write access phase
    rd_acc = psel & penable & ~pwrite;                // Read access phase
    for (int t = 1; t <= `TTC_NUM_TIMERS; t++)
    begin
      check_value($sformatf("clk_ctrl_reg_sel[%0d]", t), clk_ctrl_reg_sel[t],
                  wr && paddr == reg_addr(0, t));
      check_value($sformatf("cntr_ctrl_reg_sel[%0d]", t), cntr_ctrl_reg_sel[t],
                  wr && paddr == reg_addr(1, t));
      check_value($sformatf("interval_reg_sel[%0d]", t), interval_reg_sel[t],
                  wr && paddr == reg_addr(3, t));
      check_value($sformatf("match_1_reg_sel[%0d]", t), match_1_reg_sel[t],
                  wr && paddr == reg_addr(4, t));
      check_value($sformatf("match_2_reg_sel[%0d]", t), match_2_reg_sel[t],
                  wr && paddr == reg_addr(5, t));
      check_value($sformatf("match_3_reg_sel[%0d]", t), match_3_reg_sel[t],
                  wr && paddr == reg_addr(6, t));
      check_value($sformatf("intr_en_reg_sel[%0d]", t), intr_en_reg_sel[t],
                  wr && paddr == reg_addr(8, t));
      check_value($sformatf("clear_interrupt[%0d]", t), clear_interrupt[t],
                  rd_acc && paddr == reg_addr(7, t));
    end
    check_value("prdata", prdata, exp_prdata);       // Previous cycle's read
    exp_prdata = model_read_word();                   // Due after next edge
  endtask

  initial
  begin
    seed        = 32'h3be4;
    pclk28      = 1'b0;
    n_p_reset28 = 1'b0;
    psel        = 1'b1;                               // Read held during reset
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;                                 // Timer 1 clock control
    exp_prdata  = '0;                                 // Reset value
    for (int t = 1; t <= `TTC_NUM_TIMERS; t++)
    begin
      clk_ctrl_reg[t]     = '0;
      cntr_ctrl_reg[t]    = '0;
      counter_val_reg[t]  = '0;
      interval_reg[t]     = '0;
      match_1_reg[t]      = '0;
      match_2_reg[t]      = '0;
      match_3_reg[t]      = '0;
      interrupt_reg[t]    = '0;
      interrupt_en_reg[t] = '0;
    end
    clk_ctrl_reg[1] = 7'h55;                          // Nonzero word under the read
    repeat (2) @(posedge pclk28);                     // Reset for 2 cycles
    n_p_reset28 <= 1'b1;
    psel        <= 1'b0;                              // Bus idle from release
  end

  initial
  begin
    wait_cycles = 0;
    @(posedge pclk28);
    @(negedge pclk28);                                // Reset still asserted
    check_value("prdata", prdata, 32'h0);            // Reset overrides the read
    while (n_p_reset28 !== 1'b1)
    begin
      @(posedge pclk28);
      wait_cycles++;
      if (wait_cycles > reset_timeout)
      begin
        stop_with_failure("Timeout: reset was never released");
      end
    end
    @(negedge pclk28);
    check_value("prdata", prdata, 32'h0);            // Zero after reset
    for (int i = 0; i < num_cycles; i++)
    begin
      @(posedge pclk28);
      drive_random_cycle();
      @(negedge pclk28);                              // Outputs settled here
      check_outputs();
    end
    if (dut_i.props_i.fail_count == 0)
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("Assertion failures: %0d", dut_i.props_i.fail_count);
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== tests/ttc_apb_regs_props.sv ====
/*
 * Concurrent properties on the timer/counter register block top level.
 * Bound into every ttc_apb_regs instance; failures raise $error.
 */

`include "ttc_defines.svh"

module ttc_apb_regs_props (
  input logic                     pclk28,
  input logic                     n_p_reset28,
  input logic                     psel,
  input logic                     pwrite,
  input ttc_pkg::prdata_t         prdata,
  input logic [`TTC_NUM_TIMERS:1] clk_ctrl_reg_sel,
  input logic [`TTC_NUM_TIMERS:1] cntr_ctrl_reg_sel,
  input logic [`TTC_NUM_TIMERS:1] interval_reg_sel,
  input logic [`TTC_NUM_TIMERS:1] match_1_reg_sel,
  input logic [`TTC_NUM_TIMERS:1] match_2_reg_sel,
  input logic [`TTC_NUM_TIMERS:1] match_3_reg_sel,
  input logic [`TTC_NUM_TIMERS:1] intr_en_reg_sel,
  input logic [`TTC_NUM_TIMERS:1] clear_interrupt
);

  import ttc_pkg::*;

  int unsigned fail_count = 0;                        // Failed assertion count

  // Address ranges are disjoint, so one write hits one register at most
  assert property (@(posedge pclk28) disable iff (!n_p_reset28)
    $onehot0({clk_ctrl_reg_sel, cntr_ctrl_reg_sel, interval_reg_sel, match_1_reg_sel,
              match_2_reg_sel, match_3_reg_sel, intr_en_reg_sel}))
  else
  begin
    fail_count++;
    $error("More than one write select high");
  end

  assert property (@(posedge pclk28) disable iff (!n_p_reset28)
    pwrite |-> (clear_interrupt == '0))               // Clear only on reads
  else
  begin
    fail_count++;
    $error("Interrupt clear during a write");
  end

  assert property (@(posedge pclk28) disable iff (!n_p_reset28)
    !psel |=> (prdata == '0))                         // Idle bus reads zero
  else
  begin
    fail_count++;
    $error("Read data nonzero after an idle cycle");
  end

endmodule

bind ttc_apb_regs ttc_apb_regs_props props_i (
  .pclk28            (pclk28),
  .n_p_reset28       (n_p_reset28),
  .psel              (psel),
  .pwrite            (pwrite),
  .prdata            (prdata),
  .clk_ctrl_reg_sel  (clk_ctrl_reg_sel),
  .cntr_ctrl_reg_sel (cntr_ctrl_reg_sel),
  .interval_reg_sel  (interval_reg_sel),
  .match_1_reg_sel   (match_1_reg_sel),
  .match_2_reg_sel   (match_2_reg_sel),
  .match_3_reg_sel   (match_3_reg_sel),
  .intr_en_reg_sel   (intr_en_reg_sel),
  .clear_interrupt   (clear_interrupt)
);

// ==== src/ttc_apb_regs.sv ====
/*
 * APB register interface of the triple timer/counter.
 * Forms the bus strobes, decodes each timer in its own slice and returns
 * registered read data one cycle after the address is presented.
 * Counters, dividers and interrupt logic connect through the loose ports.
 */

`include "ttc_defines.svh"

module ttc_apb_regs (
  input  logic               pclk28,                  // APB clock
  input  logic               n_p_reset28,             // Async reset, active low

  // APB slave side
  input  logic               psel,                    // Slave select
  input  logic               penable,                 // Access phase
  input  logic               pwrite,                  // 1 write, 0 read
  input  ttc_pkg::addr_t     paddr,                   // Register address

  // Register values, one element per timer
  input  ttc_pkg::ctrl_reg_t clk_ctrl_reg     [1:`TTC_NUM_TIMERS],  // Clock ctrl
  input  ttc_pkg::ctrl_reg_t cntr_ctrl_reg    [1:`TTC_NUM_TIMERS],  // Counter ctrl
  input  ttc_pkg::count_t    counter_val_reg  [1:`TTC_NUM_TIMERS],  // Count value
  input  ttc_pkg::count_t    interval_reg     [1:`TTC_NUM_TIMERS],  // Interval
  input  ttc_pkg::count_t    match_1_reg      [1:`TTC_NUM_TIMERS],  // Match 1
  input  ttc_pkg::count_t    match_2_reg      [1:`TTC_NUM_TIMERS],  // Match 2
  input  ttc_pkg::count_t    match_3_reg      [1:`TTC_NUM_TIMERS],  // Match 3
  input  ttc_pkg::irq_t      interrupt_reg    [1:`TTC_NUM_TIMERS],  // Irq status
  input  ttc_pkg::irq_t      interrupt_en_reg [1:`TTC_NUM_TIMERS],  // Irq enable

  output ttc_pkg::prdata_t   prdata,                  // Registered read data

  // Write selects and clear pulses, bit n for timer n
  output logic [`TTC_NUM_TIMERS:1] clk_ctrl_reg_sel,  // Clock ctrl write
  output logic [`TTC_NUM_TIMERS:1] cntr_ctrl_reg_sel, // Counter ctrl write
  output logic [`TTC_NUM_TIMERS:1] interval_reg_sel,  // Interval write
  output logic [`TTC_NUM_TIMERS:1] match_1_reg_sel,   // Match 1 write
  output logic [`TTC_NUM_TIMERS:1] match_2_reg_sel,   // Match 2 write
  output logic [`TTC_NUM_TIMERS:1] match_3_reg_sel,   // Match 3 write
  output logic [`TTC_NUM_TIMERS:1] intr_en_reg_sel,   // Irq enable write
  output logic [`TTC_NUM_TIMERS:1] clear_interrupt    // Irq clear on read
);

  import ttc_pkg::*;

  // -------------------------------------------------------------------------
  // Bus strobes
  // -------------------------------------------------------------------------

  logic    wr_access;                                 // Write access phase
  logic    rd_phase;                                  // Read setup or access
  prdata_t slice_rd_data [1:`TTC_NUM_TIMERS];         // Per-timer read words
  prdata_t rd_data_comb;                              // ORed read word

  assign wr_access = psel & penable & pwrite;
  assign rd_phase  = psel & ~pwrite;                  // Both read cycles

  // -------------------------------------------------------------------------
  // Timer slices
  // -------------------------------------------------------------------------

  for (genvar t = 1; t <= `TTC_NUM_TIMERS; t++)
  begin : g_timer
    ttc_timer_regs #(
      .timer_index       (t - 1)
    ) timer_regs_i (
      .paddr             (paddr),
      .wr_access         (wr_access),
      .rd_phase          (rd_phase),
      .penable           (penable),
      .clk_ctrl_reg      (clk_ctrl_reg[t]),
      .cntr_ctrl_reg     (cntr_ctrl_reg[t]),
      .counter_val_reg   (counter_val_reg[t]),
      .interval_reg      (interval_reg[t]),
      .match_1_reg       (match_1_reg[t]),
      .match_2_reg       (match_2_reg[t]),
      .match_3_reg       (match_3_reg[t]),
      .interrupt_reg     (interrupt_reg[t]),
      .interrupt_en_reg  (interrupt_en_reg[t]),
      .clk_ctrl_reg_sel  (clk_ctrl_reg_sel[t]),
      .cntr_ctrl_reg_sel (cntr_ctrl_reg_sel[t]),
      .interval_reg_sel  (interval_reg_sel[t]),
      .match_1_reg_sel   (match_1_reg_sel[t]),
      .match_2_reg_sel   (match_2_reg_sel[t]),
      .match_3_reg_sel   (match_3_reg_sel[t]),
      .intr_en_reg_sel   (intr_en_reg_sel[t]),
      .clear_interrupt   (clear_interrupt[t]),
      .rd_data           (slice_rd_data[t])
    );
  end

  // -------------------------------------------------------------------------
  // Read data
  // -------------------------------------------------------------------------

  // Slice address ranges are disjoint, so at most one word is nonzero
  always_comb
  begin
    rd_data_comb = '0;
    for (int i = 1; i <= `TTC_NUM_TIMERS; i++)
    begin
      rd_data_comb = rd_data_comb | slice_rd_data[i];
    end
  end

  // Loaded every cycle; slices already return zero outside a read
  always_ff @(posedge pclk28 or negedge n_p_reset28)
  begin
    if (!n_p_reset28)
    begin
      prdata <= '0;                                   // Bus reads zero after reset
    end
    else
    begin
      prdata <= rd_data_comb;                         // Valid in access cycle
    end
  end

endmodule

// ==== src/ttc_timer_regs.sv ====
/*
 * Register decode for one timer channel.
 * Turns the APB address into this timer's write selects, the interrupt
 * clear pulse and a read data word that is zero unless this timer is read.
 * Instantiate once per timer with timer_index 0 for timer 1 and so on.
 */

`include "ttc_defines.svh"

module ttc_timer_regs #(
  parameter int timer_index = 0                       // 0 selects timer 1
) (
  // Bus side
  input  ttc_pkg::addr_t    paddr,                    // APB address
  input  logic              wr_access,                // Write access phase
  input  logic              rd_phase,                 // Read setup or access
  input  logic              penable,                  // APB access phase

  // Register values from this timer
  input  ttc_pkg::ctrl_reg_t clk_ctrl_reg,            // Clock control
  input  ttc_pkg::ctrl_reg_t cntr_ctrl_reg,           // Counter control
  input  ttc_pkg::count_t    counter_val_reg,         // Live counter value
  input  ttc_pkg::count_t    interval_reg,            // Interval
  input  ttc_pkg::count_t    match_1_reg,             // Match 1
  input  ttc_pkg::count_t    match_2_reg,             // Match 2
  input  ttc_pkg::count_t    match_3_reg,             // Match 3
  input  ttc_pkg::irq_t      interrupt_reg,           // Interrupt status
  input  ttc_pkg::irq_t      interrupt_en_reg,        // Interrupt enable

  // Write selects to this timer
  output logic              clk_ctrl_reg_sel,         // Clock control write
  output logic              cntr_ctrl_reg_sel,        // Counter control write
  output logic              interval_reg_sel,         // Interval write
  output logic              match_1_reg_sel,          // Match 1 write
  output logic              match_2_reg_sel,          // Match 2 write
  output logic              match_3_reg_sel,          // Match 3 write
  output logic              intr_en_reg_sel,          // Interrupt enable write

  output logic              clear_interrupt,          // Clear status on read
  output ttc_pkg::prdata_t  rd_data                   // Zero when not read
);

  import ttc_pkg::*;

  // -------------------------------------------------------------------------
  // This timer's addresses
  // -------------------------------------------------------------------------

  localparam int reg_offset = timer_index * `TTC_TIMER_STRIDE;  // Timer step

  localparam addr_t clk_ctrl_addr  = addr_t'(`TTC_CLK_CTRL_BASE  + reg_offset);
  localparam addr_t cntr_ctrl_addr = addr_t'(`TTC_CNTR_CTRL_BASE + reg_offset);
  localparam addr_t cntr_val_addr  = addr_t'(`TTC_CNTR_VAL_BASE  + reg_offset);
  localparam addr_t interval_addr  = addr_t'(`TTC_INTERVAL_BASE  + reg_offset);
  localparam addr_t match_1_addr   = addr_t'(`TTC_MATCH_1_BASE   + reg_offset);
  localparam addr_t match_2_addr   = addr_t'(`TTC_MATCH_2_BASE   + reg_offset);
  localparam addr_t match_3_addr   = addr_t'(`TTC_MATCH_3_BASE   + reg_offset);
  localparam addr_t irq_addr       = addr_t'(`TTC_IRQ_BASE       + reg_offset);
  localparam addr_t irq_en_addr    = addr_t'(`TTC_IRQ_EN_BASE    + reg_offset);

  // -------------------------------------------------------------------------
  // Write selects
  // -------------------------------------------------------------------------

  // Counter value and interrupt status are read only, so no select for them
  assign clk_ctrl_reg_sel  = wr_access & (paddr == clk_ctrl_addr);   // Clock ctrl
  assign cntr_ctrl_reg_sel = wr_access & (paddr == cntr_ctrl_addr);  // Counter ctrl
  assign interval_reg_sel  = wr_access & (paddr == interval_addr);   // Interval
  assign match_1_reg_sel   = wr_access & (paddr == match_1_addr);    // Match 1
  assign match_2_reg_sel   = wr_access & (paddr == match_2_addr);    // Match 2
  assign match_3_reg_sel   = wr_access & (paddr == match_3_addr);    // Match 3
  assign intr_en_reg_sel   = wr_access & (paddr == irq_en_addr);     // Irq enable

  // Status clears in the access cycle only, after the setup cycle
  // has already sampled it into prdata
  assign clear_interrupt = rd_phase & penable & (paddr == irq_addr);

  // -------------------------------------------------------------------------
  // Read mux
  // -------------------------------------------------------------------------

  always_comb
  begin
    rd_data = '0;                                     // Idle or other timer
    if (rd_phase)
    begin
      case (paddr)
        clk_ctrl_addr  : rd_data = prdata_t'(clk_ctrl_reg);      // Zero-extend
        cntr_ctrl_addr : rd_data = prdata_t'(cntr_ctrl_reg);
        cntr_val_addr  : rd_data = prdata_t'(counter_val_reg);
        interval_addr  : rd_data = prdata_t'(interval_reg);
        match_1_addr   : rd_data = prdata_t'(match_1_reg);
        match_2_addr   : rd_data = prdata_t'(match_2_reg);
        match_3_addr   : rd_data = prdata_t'(match_3_reg);
        irq_addr       : rd_data = prdata_t'(interrupt_reg);     // Pre-clear value
        irq_en_addr    : rd_data = prdata_t'(interrupt_en_reg);
        default        : rd_data = '0;                           // Not this timer
      endcase
    end
  end

endmodule

// ==== src/ttc_pkg.sv ====
/*
 * Types shared by the timer/counter register block.
 * Widths come from the defines header; modules import this package in
 * their body and use scoped names in their port lists.
 */

`include "ttc_defines.svh"

package ttc_pkg;

  // -------------------------------------------------------------------------
  // Bus side
  // -------------------------------------------------------------------------

  typedef logic [`TTC_ADDR_W-1:0]  addr_t;      // APB address
  typedef logic [`TTC_DATA_W-1:0]  prdata_t;    // APB read data word

  // -------------------------------------------------------------------------
  // Timer register fields
  // -------------------------------------------------------------------------

  typedef logic [`TTC_CTRL_W-1:0]  ctrl_reg_t;  // Clock or counter control
  typedef logic [`TTC_COUNT_W-1:0] count_t;     // Count, interval or match
  typedef logic [`TTC_IRQ_W-1:0]   irq_t;       // Interrupt or enable bits

endpackage

// ==== src/ttc_defines.svh ====
/*
 * Address map and field widths of the triple timer/counter register block.
 * Each register kind has a base address for timer 1; timers 2 and 3 follow
 * at TTC_TIMER_STRIDE. Include this file wherever the macros are needed.
 */

`ifndef TTC_DEFINES_SVH
`define TTC_DEFINES_SVH

// ---------------------------------------------------------------------------
// Block size
// ---------------------------------------------------------------------------

`define TTC_NUM_TIMERS     3       // Timer channels in the block

// ---------------------------------------------------------------------------
// Bus and field widths
// ---------------------------------------------------------------------------

`define TTC_ADDR_W         8       // APB address width
`define TTC_DATA_W         32      // APB read data width
`define TTC_CTRL_W         7       // Clock and counter control fields
`define TTC_COUNT_W        16      // Counter, interval and match fields
`define TTC_IRQ_W          6       // Interrupt and interrupt enable fields

// ---------------------------------------------------------------------------
// Address map
// ---------------------------------------------------------------------------

`define TTC_TIMER_STRIDE   4       // Step from one timer to the next

// Timer 1 address of each register kind
`define TTC_CLK_CTRL_BASE  8'h00   // Clock control
`define TTC_CNTR_CTRL_BASE 8'h0C   // Counter control
`define TTC_CNTR_VAL_BASE  8'h18   // Counter value, read only
`define TTC_INTERVAL_BASE  8'h24   // Interval
`define TTC_MATCH_1_BASE   8'h30   // Match 1
`define TTC_MATCH_2_BASE   8'h3C   // Match 2
`define TTC_MATCH_3_BASE   8'h48   // Match 3
`define TTC_IRQ_BASE       8'h54   // Interrupt status, cleared on read
`define TTC_IRQ_EN_BASE    8'h60   // Interrupt enable

`endif
